// File: src/mdu_pkg.sv
`default_nettype none

package mdu_pkg;

    // one machine word, operand or HI/LO value
    typedef logic [31:0] word_t;

    // full product, or {remainder, quotient}
    typedef logic [63:0] dword_t;

    // restoring divider runs one iteration per quotient bit
    localparam int DIV_BITS = 32;

    // operations seen by the multiply-divide unit
    typedef enum logic [2:0] {
        MDU_NONE,
        // signed / unsigned multiply
        MULT,
        MULTU,
        // signed / unsigned divide
        DIV,
        DIVU,
        // direct register moves from the operand bus
        MTHI,
        MTLO
    } mdu_op_t;

endpackage

`default_nettype wire

// File: src/mdu_result_if.sv
`default_nettype none

interface mdu_result_if
    import mdu_pkg::*;
();

    // result halves
    word_t hi;
    word_t lo;
    // single-cycle write strobes, no back-pressure
    logic  hi_we;
    logic  lo_we;

    // sequencer side
    modport source (output hi, lo, hi_we, lo_we);

    // register pair side
    modport sink (input hi, lo, hi_we, lo_we);

endinterface

`default_nettype wire

// File: src/multiplier.sv
`default_nettype none

module multiplier
    import mdu_pkg::*;
#(
    parameter int MULT_STAGES = 3
) (
    input  logic   clk,
    input  word_t  a,
    input  word_t  b,
    input  logic   is_signed,
    output dword_t hilo
);

    // operands widened by one bit so a single signed multiply covers both modes
    logic signed [32:0] a_ext;
    logic signed [32:0] b_ext;
    // only the low 64 bits of the 66-bit product matter
    logic signed [63:0] prod;

    // product shift chain, one entry per stage
    dword_t pipe [MULT_STAGES];

    // sign bit for MULT, zero for MULTU
    assign a_ext = {is_signed & a[31], a};
    assign b_ext = {is_signed & b[31], b};

    // operands sign-extend to 64 bits in this context
    assign prod = a_ext * b_ext;

    // plain register chain, left for the synthesis tool to retime
    always_ff @(posedge clk) begin
        pipe[0] <= prod;
        for (int i = 1; i < MULT_STAGES; i++) begin
            // each stage holds its own product
            pipe[i] <= pipe[i-1];
        end
    end

    // fixed latency of MULT_STAGES edges
    assign hilo = pipe[MULT_STAGES-1];

endmodule

`default_nettype wire

// File: src/divider.sv
`default_nettype none

module divider
    import mdu_pkg::*;
(
    input  logic   clk,
    input  logic   resetn,
    input  logic   flush,
    input  logic   start,
    input  logic   is_signed,
    input  word_t  a,
    input  word_t  b,
    output dword_t hilo,
    output logic   done
);

    localparam int CNT_W = $clog2(DIV_BITS);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        FIXUP
    } state_t;

    state_t state;
    logic [CNT_W-1:0] step;

    // operand magnitudes at start
    word_t a_mag;
    word_t b_mag;

    // working registers
    word_t divisor;
    word_t rem;
    word_t quo;
    logic  neg_q;
    logic  neg_r;

    // one restoring step
    logic [32:0] rem_sh;
    logic [33:0] diff;
    logic        take;

    // two's complement magnitude for signed operands
    assign a_mag = (is_signed && a[31]) ? -a : a;
    assign b_mag = (is_signed && b[31]) ? -b : b;

    // shift next dividend bit into the partial remainder
    assign rem_sh = {rem, quo[31]};
    assign diff   = {1'b0, rem_sh} - {2'b0, divisor};
    // no borrow means the divisor fits
    assign take   = ~diff[33];

    // control, cleared by reset and by flush
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= IDLE;
            step  <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            if (flush) begin
                // abort, nothing reported
                state <= IDLE;
            end else begin
                case (state)
                    IDLE: begin
                        if (start) begin
                            state <= RUN;
                            step  <= '0;
                        end
                    end
                    RUN: begin
                        step <= step + CNT_W'(1);
                        // last quotient bit this cycle
                        if (step == CNT_W'(DIV_BITS - 1)) begin
                            state <= FIXUP;
                        end
                    end
                    FIXUP: begin
                        state <= IDLE;
                        done  <= 1'b1;
                    end
                    default: begin
                        state <= IDLE;
                    end
                endcase
            end
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        case (state)
            IDLE: begin
                if (start) begin
                    divisor <= b_mag;
                    quo     <= a_mag;
                    rem     <= '0;
                    // quotient sign from both, remainder sign follows dividend
                    neg_q   <= is_signed & (a[31] ^ b[31]);
                    neg_r   <= is_signed & a[31];
                end
            end
            RUN: begin
                // divide by zero keeps taking, so quotient ends all ones
                rem <= take ? diff[31:0] : rem_sh[31:0];
                quo <= {quo[30:0], take};
            end
            FIXUP: begin
                hilo <= {neg_r ? -rem : rem, neg_q ? -quo : quo};
            end
            default: begin
                rem <= rem;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: src/mult.sv
`default_nettype none

module mult
    import mdu_pkg::*;
#(
    parameter int MULT_STAGES = 3
) (
    input  logic         clk,
    input  logic         resetn,
    input  logic         flush,
    input  mdu_op_t      op,
    input  word_t        a,
    input  word_t        b,
    output logic         ok,
    mdu_result_if.source res
);

    localparam int CNT_W = $clog2(MULT_STAGES + 1);

    typedef enum logic {
        INIT,
        DOING
    } state_t;

    state_t state;
    state_t state_next;
    logic [CNT_W-1:0] counter;
    logic [CNT_W-1:0] counter_next;
    // kind of the operation in flight
    logic is_mul;
    logic is_mul_next;

    logic   op_mul;
    logic   op_div;
    logic   start;
    logic   finish;
    logic   wr;
    logic   div_done;
    dword_t hilo_m;
    dword_t hilo_d;
    dword_t hilo_sel;

    assign op_mul = (op == MULT) || (op == MULTU);
    assign op_div = (op == DIV) || (op == DIVU);

    // multiply ends on counter expiry, divide on the divider's done
    assign finish = (state == DOING) && (is_mul ? (counter == CNT_W'(1)) : div_done);

    // idle, or handing back the unit this very cycle
    assign ok = (state == INIT) || finish;

    // ops arriving while busy are dropped
    assign start = ok && (op_mul || op_div) && !flush;

    multiplier #(
        .MULT_STAGES(MULT_STAGES)
    ) u_multiplier (
        .clk,
        .a,
        .b,
        .is_signed(op == MULT),
        .hilo     (hilo_m)
    );

    divider u_divider (
        .clk,
        .resetn,
        .flush,
        .start    (start && op_div),
        .is_signed(op == DIV),
        .a,
        .b,
        .hilo     (hilo_d),
        .done     (div_done)
    );

    always_comb begin
        state_next   = state;
        counter_next = counter;
        is_mul_next  = is_mul;
        case (state)
            INIT: begin
                if (start) begin
                    state_next   = DOING;
                    is_mul_next  = op_mul;
                    counter_next = CNT_W'(MULT_STAGES);
                end
            end
            DOING: begin
                if (start) begin
                    // back-to-back op taken in the result cycle
                    is_mul_next  = op_mul;
                    counter_next = CNT_W'(MULT_STAGES);
                end else if (finish) begin
                    state_next = INIT;
                end else if (is_mul) begin
                    counter_next = counter - CNT_W'(1);
                end
            end
            default: begin
                state_next = INIT;
            end
        endcase
        // flush wins over everything
        if (flush) begin
            state_next = INIT;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state   <= INIT;
            counter <= '0;
            is_mul  <= 1'b0;
        end else begin
            state   <= state_next;
            counter <= counter_next;
            is_mul  <= is_mul_next;
        end
    end

    // pick the unit that just finished
    assign hilo_sel = is_mul ? hilo_m : hilo_d;

    // aborted operation writes nothing
    assign wr = finish && !flush;

    assign res.hi    = hilo_sel[63:32];
    assign res.lo    = hilo_sel[31:0];
    assign res.hi_we = wr;
    assign res.lo_we = wr;

endmodule

`default_nettype wire

// File: src/hilo_regs.sv
`default_nettype none

module hilo_regs
    import mdu_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  mdu_op_t    op,
    input  word_t      a,
    mdu_result_if.sink res,
    output word_t      hi,
    output word_t      lo
);

    // move decode, independent of the sequencer's busy state
    logic mthi;
    logic mtlo;

    assign mthi = (op == MTHI);
    assign mtlo = (op == MTLO);

    // HI, move beats a result landing in the same cycle
    always_ff @(posedge clk) begin
        if (!resetn) begin
            hi <= '0;
        end else if (mthi) begin
            hi <= a;
        end else if (res.hi_we) begin
            hi <= res.hi;
        end
    end

    // LO, same priority
    always_ff @(posedge clk) begin
        if (!resetn) begin
            lo <= '0;
        end else if (mtlo) begin
            lo <= a;
        end else if (res.lo_we) begin
            lo <= res.lo;
        end
    end

endmodule

`default_nettype wire

// File: src/mdu_top.sv
`default_nettype none

module mdu_top
    import mdu_pkg::*;
#(
    parameter int MULT_STAGES = 3
) (
    input  logic    clk,
    input  logic    resetn,
    input  logic    flush,
    input  mdu_op_t op,
    input  word_t   a,
    input  word_t   b,
    output word_t   hi,
    output word_t   lo,
    output logic    ok
);

    // result path from sequencer to register pair
    mdu_result_if res_if ();

    // arithmetic sequencing, multiplier and divider
    mult #(
        .MULT_STAGES(MULT_STAGES)
    ) u_mult (
        .clk,
        .resetn,
        .flush,
        .op,
        .a,
        .b,
        .ok,
        .res(res_if.source)
    );

    // architectural HI/LO, also takes MTHI/MTLO
    hilo_regs u_hilo_regs (
        .clk,
        .resetn,
        .op,
        .a,
        .res(res_if.sink),
        .hi,
        .lo
    );

endmodule

`default_nettype wire

// File: tests/mdu_tb.sv
`default_nettype none

module mdu_tb
    import mdu_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MULT_STAGES = 3;
    localparam int N_RAND      = 8;
    // longest wait for ok after an issue
    localparam int OK_LIMIT    = 40;
    // rough cycles per checked operation
    localparam int MUL_LEN     = MULT_STAGES + 3;
    localparam int DIV_LEN     = DIV_BITS + 4;
    localparam int TEST_CYCLES = 10 + (2 * N_RAND + 8) * MUL_LEN + (2 * N_RAND + 10) * DIV_LEN;
    localparam int TIMEOUT_CYCLES = TEST_CYCLES * 3 / 2;

    logic    clk;
    logic    resetn;
    logic    flush;
    mdu_op_t op;
    word_t   a;
    word_t   b;
    word_t   hi;
    word_t   lo;
    logic    ok;

    int          mismatches;
    int          failures;
    int          cycles;
    logic [31:0] lfsr;

    mdu_top #(
        .MULT_STAGES(MULT_STAGES)
    ) dut_i (
        .clk,
        .resetn,
        .flush,
        .op,
        .a,
        .b,
        .hi,
        .lo,
        .ok
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // galois lfsr over x^32 + x^22 + x^2 + x + 1
    function logic next_bit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return out;
    endfunction

    // one lfsr step per bit
    function word_t rand_word();
        word_t w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            w = {w[30:0], next_bit()};
        end
        return w;
    endfunction

    // full 64-bit product with hi in the upper word
    function dword_t mul_model(input mdu_op_t o, input word_t x, input word_t y);
        logic signed [63:0] sx;
        logic signed [63:0] sy;
        if (o == MULT) begin
            sx = $signed(x);
            sy = $signed(y);
            return sx * sy;
        end
        return {32'b0, x} * {32'b0, y};
    endfunction

    // {remainder, quotient} truncated toward zero
    function dword_t div_model(input mdu_op_t o, input word_t x, input word_t y);
        logic signed [63:0] sx;
        logic signed [63:0] sy;
        logic signed [63:0] q;
        logic signed [63:0] r;
        if (o == DIVU) begin
            // divide by zero gives all-ones quotient and the dividend as remainder
            if (y == 0) begin
                return {x, 32'hffff_ffff};
            end
            return {x % y, x / y};
        end
        // 64-bit math keeps min / -1 from overflowing
        sx = $signed(x);
        sy = $signed(y);
        q  = sx / sy;
        r  = sx % sy;
        return {r[31:0], q[31:0]};
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %08h, expected %08h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_ok(input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch ok: got %h, expected %h", got, exp);
            mismatches++;
        end
    endtask

    task automatic compare_latency(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("mismatch %s: got %0h cycles, expected %0h cycles", name, got, exp);
            mismatches++;
        end
    endtask

    // one-cycle strobe that returns at the next falling edge
    task automatic issue(input mdu_op_t o, input word_t x, input word_t y);
        @(negedge clk);
        op = o;
        a  = x;
        b  = y;
        @(negedge clk);
        op = MDU_NONE;
    endtask

    // stops at the falling edge where ok is seen high
    task automatic wait_ok(output int waited);
        waited = 0;
        while (!ok && waited < OK_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!ok) begin
            $display("error: ok did not come back within %0d cycles", OK_LIMIT);
            failures++;
        end
    endtask

    // issue, check busy, latency, then HI/LO after the write edge
    task automatic run_op(input mdu_op_t o, input word_t x, input word_t y, input dword_t exp);
        int waited;
        int exp_wait;
        exp_wait = (o == MULT || o == MULTU) ? MULT_STAGES - 1 : DIV_BITS + 1;
        issue(o, x, y);
        check_ok(ok, exp_wait == 0);
        wait_ok(waited);
        compare_latency("latency", waited, exp_wait);
        @(negedge clk);
        check_word("hi", hi, exp[63:32]);
        check_word("lo", lo, exp[31:0]);
    endtask

    task automatic reset_and_moves();
        word_t v_hi;
        word_t v_lo;
        v_hi = rand_word();
        v_lo = rand_word();
        check_ok(ok, 1'b1);
        check_word("hi", hi, '0);
        check_word("lo", lo, '0);
        // moves land on the strobe edge
        issue(MTHI, v_hi, '0);
        check_word("hi", hi, v_hi);
        check_word("lo", lo, '0);
        issue(MTLO, v_lo, '0);
        check_word("hi", hi, v_hi);
        check_word("lo", lo, v_lo);
        check_ok(ok, 1'b1);
    endtask

    task automatic multiply_ops();
        word_t   ca [4];
        word_t   cb [4];
        mdu_op_t o;
        word_t   x;
        word_t   y;
        // min negative, -1 and 0 corners
        ca = '{32'h8000_0000, 32'hffff_ffff, 32'h0000_0000, 32'h8000_0000};
        cb = '{32'hffff_ffff, 32'hffff_ffff, 32'h0000_0000, 32'h8000_0000};
        cb[2] = rand_word();
        for (int k = 0; k < 2; k++) begin
            o = (k == 0) ? MULT : MULTU;
            for (int i = 0; i < 4; i++) begin
                run_op(o, ca[i], cb[i], mul_model(o, ca[i], cb[i]));
            end
            for (int i = 0; i < N_RAND; i++) begin
                x = rand_word();
                y = rand_word();
                run_op(o, x, y, mul_model(o, x, y));
            end
        end
    endtask

    task automatic divide_ops();
        mdu_op_t o;
        word_t   x;
        word_t   y;
        for (int k = 0; k < 2; k++) begin
            o = (k == 0) ? DIV : DIVU;
            for (int i = 0; i < N_RAND; i++) begin
                x = rand_word();
                y = rand_word();
                if (y == 0) begin
                    y = 32'd1;
                end
                run_op(o, x, y, div_model(o, x, y));
            end
        end
        // sign corners where min / -1 wraps
        run_op(DIV, 32'h8000_0000, 32'hffff_ffff, div_model(DIV, 32'h8000_0000, 32'hffff_ffff));
        run_op(DIV, 32'hffff_fff9, 32'd2, div_model(DIV, 32'hffff_fff9, 32'd2));
        run_op(DIV, 32'd7, 32'hffff_fffe, div_model(DIV, 32'd7, 32'hffff_fffe));
        x = rand_word();
        run_op(DIVU, x, '0, div_model(DIVU, x, '0));
    endtask

    // second op strobed while busy must vanish
    task automatic drop_while_busy(input mdu_op_t second);
        word_t  x;
        word_t  y;
        dword_t exp;
        int     waited;
        x = rand_word();
        y = rand_word() | 32'd1;
        exp = div_model(DIVU, x, y);
        issue(DIVU, x, y);
        check_ok(ok, 1'b0);
        issue(second, rand_word(), rand_word());
        check_ok(ok, 1'b0);
        // two cycles of the first op already spent
        wait_ok(waited);
        compare_latency("busy latency", waited, DIV_BITS - 1);
        @(negedge clk);
        check_word("hi", hi, exp[63:32]);
        check_word("lo", lo, exp[31:0]);
    endtask

    task automatic busy_ops();
        drop_while_busy(MULT);
        drop_while_busy(DIV);
    endtask

    task automatic flush_ops();
        word_t hi_0;
        word_t lo_0;
        int    waited;
        hi_0 = hi;
        lo_0 = lo;
        // abort mid-run
        issue(DIV, rand_word(), 32'd3);
        repeat (10) @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        check_ok(ok, 1'b1);
        repeat (DIV_BITS + 4) @(negedge clk);
        check_word("hi", hi, hi_0);
        check_word("lo", lo, lo_0);
        // abort in the very write cycle
        issue(DIVU, rand_word(), 32'd5);
        wait_ok(waited);
        compare_latency("latency", waited, DIV_BITS + 1);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        check_ok(ok, 1'b1);
        check_word("hi", hi, hi_0);
        check_word("lo", lo, lo_0);
    endtask

    task automatic move_priority();
        word_t  x;
        word_t  y;
        word_t  v;
        dword_t exp;
        int     waited;
        x = rand_word();
        y = rand_word() | 32'd1;
        v = rand_word();
        exp = div_model(DIVU, x, y);
        issue(DIVU, x, y);
        wait_ok(waited);
        // write cycle must be the one the move lands in
        compare_latency("latency", waited, DIV_BITS + 1);
        // MTLO meets the result write on the same edge
        op = MTLO;
        a  = v;
        @(negedge clk);
        op = MDU_NONE;
        check_word("hi", hi, exp[63:32]);
        check_word("lo", lo, v);
    endtask

    initial begin
        lfsr       = 32'hd501_127d;
        mismatches = 0;
        failures   = 0;
        resetn     = 1'b0;
        flush      = 1'b0;
        op         = MDU_NONE;
        a          = '0;
        b          = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;

        reset_and_moves();
        multiply_ops();
        divide_ops();
        busy_ops();
        flush_ops();
        move_priority();

        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // watchdog on total run length
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("error: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        failures++;
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
src/mdu_pkg.sv
src/mdu_result_if.sv
src/multiplier.sv
src/divider.sv
src/mult.sv
src/hilo_regs.sv
src/mdu_top.sv
tests/mdu_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f sim.f --top-module mdu_tb -o mdu_tb_sim
./obj_dir/mdu_tb_sim > sim.log 2>&1
cat sim.log

if grep -qF '*** TEST FAILED ***' sim.log; then
    exit 1
fi
exit 0
